// ==== source/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // Byte addresses and instructions are both 32 bits wide
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // Eight fully associative lines of four words each
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = LINE_WORDS * WORD_W;
    localparam int OFFSET_W   = $clog2(LINE_W / 8);
    localparam int TAG_W      = ADDR_W - OFFSET_W;
    localparam int NUM_LINES  = 8;
    localparam int INDEX_W    = $clog2(NUM_LINES);

    localparam logic [ADDR_W-1:0] RESET_PC = '0;

    // addi x0, x0, 0
    localparam logic [WORD_W-1:0] NOP_INSTR = 32'h0000_0013;

    typedef enum logic {
        FETCH_LOOKUP,
        FETCH_MISS
    } fetch_state_e;

endpackage : fetch_pkg

`default_nettype wire

// ==== source/icache_tag.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tag (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          flush_i,
    input  logic [fetch_pkg::TAG_W-1:0]   tag_i,
    input  logic                          fill_valid_i,
    input  logic [fetch_pkg::INDEX_W-1:0] fill_index_i,
    input  logic [fetch_pkg::TAG_W-1:0]   fill_tag_i,
    output logic                          hit_o,
    output logic [fetch_pkg::INDEX_W-1:0] hit_index_o
);

    import fetch_pkg::*;

    logic [NUM_LINES-1:0] valid_q;
    logic [TAG_W-1:0]     tag_q [NUM_LINES];
    logic [NUM_LINES-1:0] match;

    // Every line is compared against the lookup tag at once
    always_comb begin
        for (int i = 0; i < NUM_LINES; i++) begin
            match[i] = valid_q[i] && (tag_q[i] == tag_i);
        end
    end

    always_comb begin
        hit_index_o = '0;
        for (int i = 0; i < NUM_LINES; i++) begin
            if (match[i]) begin
                hit_index_o = INDEX_W'(i);
            end
        end
    end

    assign hit_o = |match;

    // A fill in the same cycle as a flush still leaves its own line valid
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            if (flush_i) begin
                valid_q <= '0;
            end
            if (fill_valid_i) begin
                valid_q[fill_index_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_valid_i) begin
            tag_q[fill_index_i] <= fill_tag_i;
        end
    end

    // Refill only brings in lines that missed so a tag never sits in two slots
    assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(match))
        else $error("icache_tag: more than one line matches tag %h", tag_i);

endmodule : icache_tag

`default_nettype wire

// ==== source/icache_data.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_data (
    input  logic                          clk_i,
    input  logic                          rd_en_i,
    input  logic [fetch_pkg::INDEX_W-1:0] rd_index_i,
    input  logic [1:0]                    rd_word_i,
    output logic [fetch_pkg::WORD_W-1:0]  rd_data_o,
    input  logic                          fill_valid_i,
    input  logic [fetch_pkg::INDEX_W-1:0] fill_index_i,
    input  logic [fetch_pkg::LINE_W-1:0]  fill_line_i
);

    import fetch_pkg::*;

    logic [LINE_W-1:0] lines_q [NUM_LINES];
    logic [LINE_W-1:0] rd_line;

    assign rd_line = lines_q[rd_index_i];

    // A refill always writes the whole line
    always_ff @(posedge clk_i) begin
        if (fill_valid_i) begin
            lines_q[fill_index_i] <= fill_line_i;
        end
    end

    // Word k of a line sits in bits 32k upward
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= rd_line[rd_word_i*WORD_W +: WORD_W];
        end
    end

endmodule : icache_data

`default_nettype wire

// ==== source/icache_refill.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_refill (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          miss_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  miss_addr_i,
    output logic                          mem_req_o,
    output logic [fetch_pkg::ADDR_W-1:0]  mem_addr_o,
    input  logic                          mem_valid_i,
    input  logic [fetch_pkg::LINE_W-1:0]  mem_line_i,
    output logic                          fill_valid_o,
    output logic [fetch_pkg::INDEX_W-1:0] fill_index_o,
    output logic [fetch_pkg::TAG_W-1:0]   fill_tag_o,
    output logic [fetch_pkg::LINE_W-1:0]  fill_line_o
);

    import fetch_pkg::*;

    logic               busy_q;
    logic [TAG_W-1:0]   line_addr_q;
    logic [INDEX_W-1:0] victim_q;
    logic               start;
    logic               done;

    assign start = miss_i && !busy_q;
    assign done  = busy_q && mem_valid_i;

    // The victim pointer wraps on its own since the line count is a power of two
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q   <= 1'b0;
            victim_q <= '0;
        end else if (done) begin
            busy_q   <= 1'b0;
            victim_q <= victim_q + 1'b1;
        end else if (start) begin
            busy_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            line_addr_q <= miss_addr_i[ADDR_W-1:OFFSET_W];
        end
    end

    assign mem_req_o  = busy_q;
    assign mem_addr_o = {line_addr_q, {OFFSET_W{1'b0}}};

    // The line is committed in the same cycle the memory answers
    assign fill_valid_o = done;
    assign fill_index_o = victim_q;
    assign fill_tag_o   = line_addr_q;
    assign fill_line_o  = mem_line_i;

    assert property (@(posedge clk_i) disable iff (reset_i)
        (mem_req_o && !mem_valid_i) |=> (mem_req_o && $stable(mem_addr_o)))
        else $error("icache_refill: request dropped or address moved before valid");

endmodule : icache_refill

`default_nettype wire

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          stall_i,
    input  logic                          redirect_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  target_i,
    input  logic                          flush_i,
    output logic [fetch_pkg::WORD_W-1:0]  instr_o,
    output logic [fetch_pkg::ADDR_W-1:0]  instr_pc_o,
    output logic                          instr_valid_o,
    output logic                          hazard_o,
    output logic                          miss_o,
    output logic [fetch_pkg::ADDR_W-1:0]  miss_addr_o,
    input  logic                          fill_valid_i,
    input  logic [fetch_pkg::INDEX_W-1:0] fill_index_i,
    input  logic [fetch_pkg::TAG_W-1:0]   fill_tag_i,
    input  logic [fetch_pkg::LINE_W-1:0]  fill_line_i
);

    import fetch_pkg::*;

    fetch_state_e       state_q;
    logic [ADDR_W-1:0]  pc_q;
    logic [ADDR_W-1:0]  instr_pc_q;
    logic               instr_valid_q;
    logic               lookup;
    logic               hit;
    logic [INDEX_W-1:0] hit_index;
    logic [WORD_W-1:0]  rd_data;

    // The pc is only looked up when the stage is free to move on
    assign lookup = (state_q == FETCH_LOOKUP) && !stall_i && !redirect_i;

    assign miss_o      = lookup && !hit;
    assign miss_addr_o = pc_q;
    assign hazard_o    = (state_q == FETCH_MISS) || miss_o;

    icache_tag u_icache_tag (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .tag_i        (pc_q[ADDR_W-1:OFFSET_W]),
        .fill_valid_i (fill_valid_i),
        .fill_index_i (fill_index_i),
        .fill_tag_i   (fill_tag_i),
        .hit_o        (hit),
        .hit_index_o  (hit_index)
    );

    icache_data u_icache_data (
        .clk_i        (clk_i),
        .rd_en_i      (lookup && hit),
        .rd_index_i   (hit_index),
        .rd_word_i    (pc_q[OFFSET_W-1:2]),
        .rd_data_o    (rd_data),
        .fill_valid_i (fill_valid_i),
        .fill_index_i (fill_index_i),
        .fill_line_i  (fill_line_i)
    );

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= FETCH_LOOKUP;
        end else begin
            case (state_q)
                FETCH_LOOKUP: begin
                    if (miss_o) begin
                        state_q <= FETCH_MISS;
                    end
                end
                FETCH_MISS: begin
                    if (fill_valid_i) begin
                        state_q <= FETCH_LOOKUP;
                    end
                end
                default: state_q <= FETCH_LOOKUP;
            endcase
        end
    end

    // A redirect beats a stall but waits while a miss is in progress
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q          <= RESET_PC;
            instr_valid_q <= 1'b0;
        end else if (redirect_i && state_q == FETCH_LOOKUP) begin
            pc_q          <= target_i;
            instr_valid_q <= 1'b0;
        end else if (lookup) begin
            if (hit) begin
                pc_q <= pc_q + ADDR_W'(4);
            end
            instr_valid_q <= hit;
        end
    end

    // Captured together with the data read so the pc lines up with its word
    always_ff @(posedge clk_i) begin
        if (lookup && hit) begin
            instr_pc_q <= pc_q;
        end
    end

    assign instr_o       = instr_valid_q ? rd_data : NOP_INSTR;
    assign instr_pc_o    = instr_pc_q;
    assign instr_valid_o = instr_valid_q;

    // Nothing new reaches the output until the refill has brought the line in
    assert property (@(posedge clk_i) disable iff (reset_i)
        (state_q == FETCH_MISS) |=> !instr_valid_q)
        else $error("fetch_stage: instruction delivered during a miss");

endmodule : fetch_stage

`default_nettype wire

// ==== source/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         stall_i,
    input  logic                         redirect_i,
    input  logic [fetch_pkg::ADDR_W-1:0] target_i,
    input  logic                         flush_i,
    output logic [fetch_pkg::WORD_W-1:0] instr_o,
    output logic [fetch_pkg::ADDR_W-1:0] instr_pc_o,
    output logic                         instr_valid_o,
    output logic                         hazard_o,
    output logic                         mem_req_o,
    output logic [fetch_pkg::ADDR_W-1:0] mem_addr_o,
    input  logic                         mem_valid_i,
    input  logic [fetch_pkg::LINE_W-1:0] mem_line_i
);

    import fetch_pkg::*;

    logic               miss;
    logic [ADDR_W-1:0]  miss_addr;
    logic               fill_valid;
    logic [INDEX_W-1:0] fill_index;
    logic [TAG_W-1:0]   fill_tag;
    logic [LINE_W-1:0]  fill_line;

    fetch_stage u_fetch_stage (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .stall_i       (stall_i),
        .redirect_i    (redirect_i),
        .target_i      (target_i),
        .flush_i       (flush_i),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o),
        .instr_valid_o (instr_valid_o),
        .hazard_o      (hazard_o),
        .miss_o        (miss),
        .miss_addr_o   (miss_addr),
        .fill_valid_i  (fill_valid),
        .fill_index_i  (fill_index),
        .fill_tag_i    (fill_tag),
        .fill_line_i   (fill_line)
    );

    icache_refill u_icache_refill (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .miss_i       (miss),
        .miss_addr_i  (miss_addr),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_valid_i  (mem_valid_i),
        .mem_line_i   (mem_line_i),
        .fill_valid_o (fill_valid),
        .fill_index_o (fill_index),
        .fill_tag_o   (fill_tag),
        .fill_line_o  (fill_line)
    );

endmodule : fetch_top

`default_nettype wire

// ==== sim/tb_fetch_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_mem #(
    parameter int SEED = 16
) (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         req_i,
    input  logic [fetch_pkg::ADDR_W-1:0] addr_i,
    output logic                         valid_o,
    output logic [fetch_pkg::LINE_W-1:0] line_o
);

    import fetch_pkg::*;

    integer            seed;
    int                wait_left;
    logic              active;
    logic [ADDR_W-1:0] line_addr;
    logic [LINE_W-1:0] line;

    // Each word is built from its own byte address
    function automatic logic [WORD_W-1:0] word_at(input logic [ADDR_W-1:0] addr);
        return addr * 32'h9E37_79B1 + 32'h0000_0013;
    endfunction

    initial begin
        seed    = SEED;
        active  = 1'b0;
        valid_o = 1'b0;
        line_o  = '0;
    end

    // A request is answered 1 to 6 cycles after it is first seen
    always @(posedge clk_i) begin
        valid_o <= 1'b0;
        if (reset_i) begin
            active = 1'b0;
        end else if (active) begin
            wait_left = wait_left - 1;
            if (wait_left == 0) begin
                for (int k = 0; k < LINE_WORDS; k++) begin
                    line[k*WORD_W +: WORD_W] = word_at(line_addr + ADDR_W'(4 * k));
                end
                line_o  <= line;
                valid_o <= 1'b1;
                active  = 1'b0;
            end
        end else if (req_i && !valid_o) begin
            line_addr = addr_i;
            wait_left = 1 + (($random(seed) & 32'h7FFF_FFFF) % 6);
            active    = 1'b1;
        end
    end

endmodule : tb_fetch_mem

`default_nettype wire

// ==== sim/tb_fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

    import fetch_pkg::*;

    localparam int CYCLE_LIMIT = 6000;
    localparam int SEED        = 16;
    localparam int KIND_EMPTY  = 0;
    localparam int KIND_HOLD   = 1;
    localparam int KIND_NEW    = 2;

    logic              clk_i;
    logic              reset_i;
    logic              stall_i;
    logic              redirect_i;
    logic              flush_i;
    logic [ADDR_W-1:0] target_i;
    logic [WORD_W-1:0] instr_o;
    logic [ADDR_W-1:0] instr_pc_o;
    logic              instr_valid_o;
    logic              hazard_o;
    logic              mem_req_o;
    logic [ADDR_W-1:0] mem_addr_o;
    logic              mem_valid_i;
    logic [LINE_W-1:0] mem_line_i;

    integer            seed;
    int                cycles;
    int                value_errors;
    int                other_errors;
    int                delivered;
    int                req_count;
    int                next_kind;
    int                waited;
    int                hazard_cycles;
    logic              req_q;
    logic              held_valid;
    logic [WORD_W-1:0] held_instr;
    logic [ADDR_W-1:0] held_pc;
    logic [ADDR_W-1:0] exp_pc;
    logic [ADDR_W-1:0] deliver_pc;

    fetch_top u_fetch_top (.*);

    tb_fetch_mem #(.SEED(SEED)) u_mem (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (mem_req_o),
        .addr_i  (mem_addr_o),
        .valid_o (mem_valid_i),
        .line_o  (mem_line_i)
    );

    // Every word of memory follows from its byte address alone
    function automatic logic [WORD_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        return addr * 32'h9E37_79B1 + 32'h0000_0013;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR %0t %s: got %h expected %h", $time, name, got, expected);
            value_errors++;
        end
    endtask

    task automatic expect_requests(input int count, input string phase);
        if (req_count != count) begin
            $display("%s: %0d memory requests seen in total where %0d were expected",
                     phase, req_count, count);
            other_errors++;
        end
    endtask

    // Counts lookups that deliver, then parks the stage with a stall
    task automatic fetch_words(input int count, input logic random_stall);
        int accepted;
        accepted = 0;
        while (accepted < count) begin
            @(negedge clk_i);
            if (random_stall) begin
                stall_i = $random(seed) & 1;
            end else begin
                stall_i = 1'b0;
            end
            @(posedge clk_i);
            if (!stall_i && !hazard_o) begin
                accepted++;
            end
        end
        @(negedge clk_i);
        stall_i = 1'b1;
    endtask

    task automatic jump(input logic [ADDR_W-1:0] target);
        @(negedge clk_i);
        redirect_i = 1'b1;
        target_i   = target;
        do begin
            @(posedge clk_i);
        end while (hazard_o);
        @(negedge clk_i);
        redirect_i = 1'b0;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, %0d value errors, %0d other errors",
                     cycles, value_errors, other_errors);
            $display("Something failed");
            $finish;
        end
    end

    // Outputs seen at an edge were produced by the edge before it
    always @(posedge clk_i) begin
        if (reset_i) begin
            exp_pc    = RESET_PC;
            next_kind = KIND_EMPTY;
            req_q     = 1'b0;
        end else begin
            if (instr_valid_o === 1'b1) begin
                check_value("instr_o", instr_o, expected_word(instr_pc_o));
            end
            case (next_kind)
                KIND_NEW: begin
                    check_value("instr_valid_o", instr_valid_o, 1);
                    check_value("instr_pc_o", instr_pc_o, deliver_pc);
                end
                KIND_HOLD: begin
                    check_value("instr_valid_o", instr_valid_o, held_valid);
                    if (held_valid) begin
                        check_value("instr_o", instr_o, held_instr);
                        check_value("instr_pc_o", instr_pc_o, held_pc);
                    end
                end
                default: begin
                    check_value("instr_valid_o", instr_valid_o, 0);
                    check_value("instr_o", instr_o, NOP_INSTR);
                end
            endcase
            held_valid = instr_valid_o;
            held_instr = instr_o;
            held_pc    = instr_pc_o;
            if (mem_req_o && !req_q) begin
                req_count++;
                check_value("mem_addr_o", mem_addr_o,
                            {exp_pc[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
            end
            req_q = mem_req_o;
            // With redirect high, hazard_o only shows a miss in progress
            if (redirect_i && !hazard_o) begin
                exp_pc    = target_i;
                next_kind = KIND_EMPTY;
            end else if (hazard_o) begin
                next_kind = KIND_EMPTY;
            end else if (stall_i) begin
                next_kind = KIND_HOLD;
            end else begin
                deliver_pc = exp_pc;
                exp_pc     = exp_pc + 4;
                next_kind  = KIND_NEW;
                delivered++;
            end
        end
    end

    initial begin
        seed         = SEED;
        cycles       = 0;
        value_errors = 0;
        other_errors = 0;
        delivered    = 0;
        req_count    = 0;
        reset_i      = 1'b1;
        stall_i      = 1'b1;
        redirect_i   = 1'b0;
        flush_i      = 1'b0;
        target_i     = '0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        // Eight new lines fill every slot and the victim pointer wraps to slot 0
        fetch_words(32, 1'b0);
        expect_requests(8, "Sequential fetch");
        jump(32'h20);
        fetch_words(16, 1'b1);
        jump(32'h44);
        fetch_words(8, 1'b1);
        expect_requests(8, "Hit reuse");

        // The ninth line takes slot 0, the refetched first line then takes slot 1
        jump(32'h80);
        fetch_words(4, 1'b1);
        expect_requests(9, "Ninth line");
        jump(32'h00);
        fetch_words(4, 1'b0);
        expect_requests(10, "Refetch of evicted first line");
        jump(32'h10);
        fetch_words(4, 1'b0);
        expect_requests(11, "Refetch of evicted second line");
        jump(32'h30);
        fetch_words(4, 1'b0);
        expect_requests(11, "Line kept after replacement");

        @(negedge clk_i);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        jump(32'h30);
        stall_i       = 1'b0;
        waited        = 0;
        hazard_cycles = 0;
        do begin
            @(posedge clk_i);
            waited++;
            if (hazard_o) begin
                hazard_cycles++;
            end
            @(negedge clk_i);
        end while (instr_valid_o !== 1'b1);
        stall_i = 1'b1;
        if (waited < 3 || hazard_cycles != waited - 1) begin
            $display("After flush hazard_o was high in %0d of %0d cycles before the first fetch",
                     hazard_cycles, waited);
            other_errors++;
        end
        expect_requests(12, "Refetch after flush");

        repeat (3) @(negedge clk_i);
        $display("Checked %0d instructions, %0d value errors, %0d other errors",
                 delivered, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : tb_fetch_top

`default_nettype wire

// ==== project.f ====
source/fetch_pkg.sv
source/icache_tag.sv
source/icache_data.sv
source/icache_refill.sv
source/fetch_stage.sv
source/fetch_top.sv
sim/tb_fetch_mem.sv
sim/tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_subsystem

sources:
  - source/fetch_pkg.sv
  - source/icache_tag.sv
  - source/icache_data.sv
  - source/icache_refill.sv
  - source/fetch_stage.sv
  - source/fetch_top.sv
  - target: simulation
    files:
      - sim/tb_fetch_mem.sv
      - sim/tb_fetch_top.sv
